//--- design/uart_regs_pkg.sv
// Register slots, status bit positions, control field layouts and control structs
`default_nettype none

package uart_regs_pkg;

  // Register slots, decoded from addr[4:2]; slot 7 reads zero
  typedef enum logic [2:0] {
    TXDATA = 3'd0,
    RXDATA = 3'd1,
    TXCTRL = 3'd2,
    RXCTRL = 3'd3,
    IE     = 3'd4,
    IP     = 3'd5,
    DIV    = 3'd6
  } reg_index_t;

  // Status flags in the data words
  localparam int FULL_BIT  = 31;
  localparam int EMPTY_BIT = 31;
  localparam int FERR_BIT  = 30;

  // Control word fields
  localparam int EN_BIT    = 0;
  localparam int NSTOP_BIT = 1;
  localparam int WM_LSB    = 16;
  localparam int WM_MSB    = 18;

  localparam int DIV_WIDTH = 16;

  typedef struct packed {
    logic [2:0] watermark;
    logic       two_stop;
    logic       enable;
  } tx_ctrl_t;

  typedef struct packed {
    logic [2:0] watermark;
    logic       enable;
  } rx_ctrl_t;

  // Layout shared by IE and IP, txwm in bit 0
  typedef struct packed {
    logic rxwm;
    logic txwm;
  } irq_bits_t;

endpackage

`default_nettype wire

//--- design/uart_line_pkg.sv
// Serial frame constants and line-side payload and config types
`default_nettype none

package uart_line_pkg;

  localparam int DATA_BITS  = 8;
  localparam int OVERSAMPLE = 16;

  // Transmit FIFO payload
  typedef logic [DATA_BITS-1:0] tx_byte_t;

  // Line setup shared by both serial engines
  typedef struct packed {
    logic two_stop;
    logic enable;
  } line_cfg_t;

  // Receive FIFO payload
  typedef struct packed {
    logic                 ferr;
    logic [DATA_BITS-1:0] data;
  } rx_frame_t;

endpackage

`default_nettype wire

//--- design/uart_fifo.sv
// Show-ahead circular FIFO with occupancy count and watermark compares
`timescale 1ns/1ps
`default_nettype none

module uart_fifo #(
  parameter type payload_t = logic [7:0],
  parameter int  DEPTH     = 8
) (
  input  logic       clock,
  input  logic       reset,
  input  logic       push,
  input  payload_t   push_data,
  input  logic       pop,
  input  logic [2:0] watermark,
  output payload_t   head,
  output logic       empty,
  output logic       full,
  output logic       below_mark,
  output logic       above_mark
);

  localparam int PTR_W = $clog2(DEPTH);
  localparam int CNT_W = $clog2(DEPTH + 1);

  payload_t         mem [DEPTH];
  logic [PTR_W-1:0] rd_ptr;
  logic [PTR_W-1:0] wr_ptr;
  logic [CNT_W-1:0] count;

  function automatic logic [PTR_W-1:0] next_ptr(input logic [PTR_W-1:0] ptr);
    return (ptr == PTR_W'(DEPTH - 1)) ? '0 : ptr + 1'b1;
  endfunction

  always_ff @(posedge clock) begin
    if (push) begin
      mem[wr_ptr] <= push_data;
    end
  end

  always_ff @(posedge clock or posedge reset) begin
    if (reset) begin
      rd_ptr <= '0;
      wr_ptr <= '0;
      count  <= '0;
    end else begin
      if (push) wr_ptr <= next_ptr(wr_ptr);
      if (pop) rd_ptr <= next_ptr(rd_ptr);
      case ({push, pop})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase
    end
  end

  // Head shows the oldest entry without a pop
  assign head       = mem[rd_ptr];
  assign empty      = (count == '0);
  assign full       = (count == CNT_W'(DEPTH));
  assign below_mark = (count < CNT_W'(watermark));
  assign above_mark = (count > CNT_W'(watermark));

  no_push_when_full: assert property (@(posedge clock) disable iff (reset) full |-> !push)
    else $error("uart_fifo: push while full");
  no_pop_when_empty: assert property (@(posedge clock) disable iff (reset) empty |-> !pop)
    else $error("uart_fifo: pop while empty");

endmodule

`default_nettype wire

//--- design/uart_baud_gen.sv
// Baud generator for transmit bit ticks and 16x receive sample ticks
`timescale 1ns/1ps
`default_nettype none

module uart_baud_gen #(
  parameter int DIV_RESET = 85
) (
  input  logic                                clock,
  input  logic                                reset,
  input  logic [uart_regs_pkg::DIV_WIDTH-1:0] div,
  output logic                                bit_tick,
  output logic                                sample_tick
);

  localparam int DIV_W    = uart_regs_pkg::DIV_WIDTH;
  localparam int SHIFT    = $clog2(uart_line_pkg::OVERSAMPLE);
  localparam int SAMPLE_W = DIV_W - SHIFT;

  logic [DIV_W-1:0]    bit_cnt;
  logic [SAMPLE_W-1:0] sample_cnt;
  logic [SAMPLE_W-1:0] sample_div;

  // Sample period is the bit period over the oversampling rate
  assign sample_div  = div[DIV_W-1:SHIFT];
  assign bit_tick    = (bit_cnt == '0);
  assign sample_tick = (sample_cnt == '0);

  // Down counters reload from the divisor on their tick
  always_ff @(posedge clock or posedge reset) begin
    if (reset) begin
      bit_cnt    <= DIV_W'(DIV_RESET);
      sample_cnt <= SAMPLE_W'(DIV_RESET >> SHIFT);
    end else begin
      bit_cnt    <= bit_tick ? div : bit_cnt - 1'b1;
      sample_cnt <= sample_tick ? sample_div : sample_cnt - 1'b1;
    end
  end

endmodule

`default_nettype wire

//--- design/uart_tx.sv
// Start, data and stop bit serializer loaded from the transmit FIFO
`timescale 1ns/1ps
`default_nettype none

module uart_tx (
  input  logic                      clock,
  input  logic                      reset,
  input  uart_line_pkg::line_cfg_t  cfg,
  input  logic                      bit_tick,
  input  logic                      load,
  input  uart_line_pkg::tx_byte_t   data,
  output logic                      tx_ready,
  output logic                      txd
);

  localparam int DATA_BITS = uart_line_pkg::DATA_BITS;
  localparam int CNT_W     = $clog2(DATA_BITS);

  typedef enum logic [1:0] {TX_IDLE, TX_START, TX_DATA, TX_STOP} tx_state_t;

  tx_state_t               state;
  uart_line_pkg::tx_byte_t shift;
  logic [CNT_W-1:0]        count;
  logic [CNT_W-1:0]        last_stop;

  assign tx_ready  = (state == TX_IDLE) && cfg.enable;
  assign last_stop = cfg.two_stop ? CNT_W'(2) : CNT_W'(1);

  always_ff @(posedge clock) begin
    if (load) begin
      shift <= data;
    end else if (bit_tick && state == TX_DATA) begin
      shift <= shift >> 1;
    end
  end

  // Every line change happens on a bit tick
  always_ff @(posedge clock or posedge reset) begin
    if (reset) begin
      state <= TX_IDLE;
      count <= '0;
      txd   <= 1'b1;
    end else begin
      case (state)
        TX_IDLE: if (load) state <= TX_START;
        TX_START: if (bit_tick) begin
          txd   <= 1'b0;
          count <= '0;
          state <= TX_DATA;
        end
        TX_DATA: if (bit_tick) begin
          txd   <= shift[0];
          count <= count + 1'b1;
          if (count == CNT_W'(DATA_BITS - 1)) state <= TX_STOP;
        end
        default: if (bit_tick) begin
          // Count 0 starts the first stop bit, leave after the last one
          txd   <= 1'b1;
          count <= count + 1'b1;
          if (count == last_stop) state <= TX_IDLE;
        end
      endcase
    end
  end

  load_when_ready: assert property (@(posedge clock) disable iff (reset) load |-> tx_ready)
    else $error("uart_tx: load while not ready");

endmodule

`default_nettype wire

//--- design/uart_rx.sv
// Oversampling deserializer with start-bit qualification and stop-bit check
`timescale 1ns/1ps
`default_nettype none

module uart_rx (
  input  logic                      clock,
  input  logic                      reset,
  input  uart_line_pkg::line_cfg_t  cfg,
  input  logic                      sample_tick,
  input  logic                      rxd,
  output logic                      rx_valid,
  output uart_line_pkg::rx_frame_t  frame
);

  localparam int DATA_BITS  = uart_line_pkg::DATA_BITS;
  localparam int OVERSAMPLE = uart_line_pkg::OVERSAMPLE;
  localparam int SAMP_W     = $clog2(OVERSAMPLE);
  localparam int BIT_W      = $clog2(DATA_BITS);

  typedef enum logic [1:0] {RX_IDLE, RX_START, RX_DATA, RX_STOP} rx_state_t;

  rx_state_t            state;
  logic                 rxd_meta;
  logic                 rxd_sync;
  logic                 line_prev;
  logic [SAMP_W-1:0]    samp;
  logic [BIT_W-1:0]     bit_cnt;
  logic [DATA_BITS-1:0] shift;
  logic                 mid_start;
  logic                 mid_bit;

  // Half a bit after the edge, then one full bit per later sample point
  assign mid_start = (samp == SAMP_W'(OVERSAMPLE / 2 - 1));
  assign mid_bit   = (samp == SAMP_W'(OVERSAMPLE - 1));

  always_ff @(posedge clock or posedge reset) begin
    if (reset) begin
      rxd_meta <= 1'b1;
      rxd_sync <= 1'b1;
    end else begin
      rxd_meta <= rxd;
      rxd_sync <= rxd_meta;
    end
  end

  always_ff @(posedge clock) begin
    if (sample_tick && state == RX_DATA && mid_bit) begin
      shift <= {rxd_sync, shift[DATA_BITS-1:1]};
    end
    if (sample_tick && state == RX_STOP && mid_bit) begin
      frame <= '{ferr: !rxd_sync, data: shift};
    end
  end

  always_ff @(posedge clock or posedge reset) begin
    if (reset) begin
      state     <= RX_IDLE;
      samp      <= '0;
      bit_cnt   <= '0;
      line_prev <= 1'b1;
      rx_valid  <= 1'b0;
    end else begin
      rx_valid <= 1'b0;
      if (sample_tick) begin
        line_prev <= rxd_sync;
        samp      <= samp + 1'b1;
      end
      if (!cfg.enable) begin
        state <= RX_IDLE;
      end else if (sample_tick) begin
        case (state)
          RX_IDLE: if (line_prev && !rxd_sync) begin
            samp  <= '0;
            state <= RX_START;
          end
          RX_START: if (mid_start) begin
            // A glitch that is high again by now is not a start bit
            samp    <= '0;
            bit_cnt <= '0;
            state   <= rxd_sync ? RX_IDLE : RX_DATA;
          end
          RX_DATA: if (mid_bit) begin
            bit_cnt <= bit_cnt + 1'b1;
            if (bit_cnt == BIT_W'(DATA_BITS - 1)) state <= RX_STOP;
          end
          default: if (mid_bit) begin
            rx_valid <= 1'b1;
            state    <= RX_IDLE;
          end
        endcase
      end
    end
  end

endmodule

`default_nettype wire

//--- design/uart.sv
// UART top with bus sequencer, register file, read mux, interrupt logic and instances
`timescale 1ns/1ps
`default_nettype none

module uart #(
  parameter int CLOCK_FREQ_HZ = 10_000_000,
  parameter int BAUD_RATE     = 115_200,
  parameter int FIFO_DEPTH    = 8
) (
  input  logic        clock,
  input  logic        reset,
  input  logic        rd_en,
  input  logic        wr_en,
  input  logic [4:0]  addr,
  input  logic [31:0] wr_data,
  input  logic        rxd,
  output logic [31:0] rd_data,
  output logic        busy,
  output logic        irq,
  output logic        txd
);

  localparam int DIV_RESET = CLOCK_FREQ_HZ / BAUD_RATE - 1;
  localparam int DIV_W     = uart_regs_pkg::DIV_WIDTH;
  localparam int DATA_BITS = uart_line_pkg::DATA_BITS;

  typedef enum logic [1:0] {SEQ_IDLE, SEQ_ACCESS, SEQ_RECOVER} seq_state_t;

  typedef struct packed {
    logic                      is_read;
    uart_regs_pkg::reg_index_t slot;
    logic [31:0]               data;
  } bus_req_t;

  seq_state_t                seq_state;
  bus_req_t                  req;
  logic                      do_read;
  logic                      do_write;
  logic [31:0]               read_word;

  uart_regs_pkg::tx_ctrl_t   tx_ctrl;
  uart_regs_pkg::rx_ctrl_t   rx_ctrl;
  uart_regs_pkg::irq_bits_t  ie;
  uart_regs_pkg::irq_bits_t  ip;
  logic [DIV_W-1:0]          div;

  logic                      bit_tick;
  logic                      sample_tick;
  uart_line_pkg::line_cfg_t  tx_cfg;
  uart_line_pkg::line_cfg_t  rx_cfg;

  logic                      tx_push;
  logic                      tx_load;
  logic                      tx_ready;
  logic                      tx_empty;
  logic                      tx_full;
  logic                      tx_below;
  uart_line_pkg::tx_byte_t   tx_head;

  logic                      rx_valid;
  logic                      rx_push;
  logic                      rx_pop;
  logic                      rx_empty;
  logic                      rx_full;
  logic                      rx_above;
  uart_line_pkg::rx_frame_t  rx_frame;
  uart_line_pkg::rx_frame_t  rx_head;

  // Bus sequencer, a request is taken only while idle
  always_ff @(posedge clock or posedge reset) begin
    if (reset) begin
      seq_state <= SEQ_IDLE;
    end else begin
      case (seq_state)
        SEQ_IDLE:   if (rd_en || wr_en) seq_state <= SEQ_ACCESS;
        SEQ_ACCESS: seq_state <= SEQ_RECOVER;
        default:    seq_state <= SEQ_IDLE;
      endcase
    end
  end

  // Read wins over write
  always_ff @(posedge clock) begin
    if (seq_state == SEQ_IDLE && (rd_en || wr_en)) begin
      req.is_read <= rd_en;
      req.slot    <= uart_regs_pkg::reg_index_t'(addr[4:2]);
      req.data    <= wr_data;
    end
  end

  assign busy     = (seq_state != SEQ_IDLE);
  assign do_read  = (seq_state == SEQ_ACCESS) && req.is_read;
  assign do_write = (seq_state == SEQ_ACCESS) && !req.is_read;

  always_ff @(posedge clock or posedge reset) begin
    if (reset) begin
      tx_ctrl <= '0;
      rx_ctrl <= '0;
      ie      <= '0;
      div     <= DIV_W'(DIV_RESET);
    end else if (do_write) begin
      case (req.slot)
        uart_regs_pkg::TXCTRL: begin
          tx_ctrl.enable    <= req.data[uart_regs_pkg::EN_BIT];
          tx_ctrl.two_stop  <= req.data[uart_regs_pkg::NSTOP_BIT];
          tx_ctrl.watermark <= req.data[uart_regs_pkg::WM_MSB:uart_regs_pkg::WM_LSB];
        end
        uart_regs_pkg::RXCTRL: begin
          rx_ctrl.enable    <= req.data[uart_regs_pkg::EN_BIT];
          rx_ctrl.watermark <= req.data[uart_regs_pkg::WM_MSB:uart_regs_pkg::WM_LSB];
        end
        uart_regs_pkg::IE:  ie  <= req.data[1:0];
        uart_regs_pkg::DIV: div <= req.data[DIV_W-1:0];
        default: ;
      endcase
    end
  end

  // Read mux, undefined bits and slot 7 stay zero
  always_comb begin
    read_word = '0;
    case (req.slot)
      uart_regs_pkg::TXDATA: read_word[uart_regs_pkg::FULL_BIT] = tx_full;
      uart_regs_pkg::RXDATA: begin
        read_word[uart_regs_pkg::EMPTY_BIT] = rx_empty;
        if (!rx_empty) begin
          read_word[uart_regs_pkg::FERR_BIT] = rx_head.ferr;
          read_word[DATA_BITS-1:0]           = rx_head.data;
        end
      end
      uart_regs_pkg::TXCTRL: begin
        read_word[uart_regs_pkg::EN_BIT]                       = tx_ctrl.enable;
        read_word[uart_regs_pkg::NSTOP_BIT]                    = tx_ctrl.two_stop;
        read_word[uart_regs_pkg::WM_MSB:uart_regs_pkg::WM_LSB] = tx_ctrl.watermark;
      end
      uart_regs_pkg::RXCTRL: begin
        read_word[uart_regs_pkg::EN_BIT]                       = rx_ctrl.enable;
        read_word[uart_regs_pkg::WM_MSB:uart_regs_pkg::WM_LSB] = rx_ctrl.watermark;
      end
      uart_regs_pkg::IE:  read_word[1:0]       = ie;
      uart_regs_pkg::IP:  read_word[1:0]       = ip;
      uart_regs_pkg::DIV: read_word[DIV_W-1:0] = div;
      default: ;
    endcase
  end

  // Read data holds until the next read
  always_ff @(posedge clock or posedge reset) begin
    if (reset) begin
      rd_data <= '0;
      irq     <= 1'b0;
    end else begin
      if (do_read) rd_data <= read_word;
      irq <= |ip;
    end
  end

  assign ip = '{rxwm: rx_above && ie.rxwm, txwm: tx_below && ie.txwm};

  // Bytes to a full FIFO and frames into a full FIFO are dropped
  assign tx_push = do_write && (req.slot == uart_regs_pkg::TXDATA) && !tx_full;
  assign tx_load = tx_ready && !tx_empty;
  assign rx_pop  = do_read && (req.slot == uart_regs_pkg::RXDATA) && !rx_empty;
  assign rx_push = rx_valid && !rx_full;

  assign tx_cfg = '{two_stop: tx_ctrl.two_stop, enable: tx_ctrl.enable};
  assign rx_cfg = '{two_stop: tx_ctrl.two_stop, enable: rx_ctrl.enable};

  uart_baud_gen #(.DIV_RESET(DIV_RESET)) baud_gen_inst (
    .clock(clock), .reset(reset), .div(div),
    .bit_tick(bit_tick), .sample_tick(sample_tick)
  );

  uart_fifo #(.payload_t(uart_line_pkg::tx_byte_t), .DEPTH(FIFO_DEPTH)) tx_fifo_inst (
    .clock(clock), .reset(reset),
    .push(tx_push), .push_data(req.data[DATA_BITS-1:0]),
    .pop(tx_load), .watermark(tx_ctrl.watermark),
    .head(tx_head), .empty(tx_empty), .full(tx_full),
    .below_mark(tx_below), .above_mark()
  );

  uart_fifo #(.payload_t(uart_line_pkg::rx_frame_t), .DEPTH(FIFO_DEPTH)) rx_fifo_inst (
    .clock(clock), .reset(reset),
    .push(rx_push), .push_data(rx_frame),
    .pop(rx_pop), .watermark(rx_ctrl.watermark),
    .head(rx_head), .empty(rx_empty), .full(rx_full),
    .below_mark(), .above_mark(rx_above)
  );

  uart_tx tx_inst (
    .clock(clock), .reset(reset), .cfg(tx_cfg), .bit_tick(bit_tick),
    .load(tx_load), .data(tx_head), .tx_ready(tx_ready), .txd(txd)
  );

  uart_rx rx_inst (
    .clock(clock), .reset(reset), .cfg(rx_cfg), .sample_tick(sample_tick),
    .rxd(rxd), .rx_valid(rx_valid), .frame(rx_frame)
  );

  busy_two_cycles: assert property (@(posedge clock) disable iff (reset) busy [*2] |=> !busy)
    else $error("uart: busy held longer than two cycles");

endmodule

`default_nettype wire

//--- testbench/uart_tb.sv
// UART testbench with bus tasks, serial driver and monitor, register model and checks
`timescale 1ns/1ps
`default_nettype none

module uart_tb;

  localparam int CLOCK_FREQ_HZ = 10_000_000;
  localparam int BAUD_RATE     = 115_200;
  localparam int FIFO_DEPTH    = 8;
  localparam int BIT_CYCLES    = 16;
  localparam int CYCLE_LIMIT   = 15_000;

  logic        clock;
  logic        reset;
  logic        rd_en;
  logic        wr_en;
  logic [4:0]  addr;
  logic [31:0] wr_data;
  logic        rxd;
  logic [31:0] rd_data;
  logic        busy;
  logic        irq;
  logic        txd;

  // Register model and expected FIFO contents
  logic        m_tx_en;
  logic        m_tx_two;
  logic [2:0]  m_tx_wm;
  logic        m_rx_en;
  logic [2:0]  m_rx_wm;
  logic [1:0]  m_ie;
  logic [15:0] m_div;
  logic [7:0]  exp_tx[$];
  // Receive entries as {ferr, data}
  logic [8:0]  exp_rx[$];

  logic [31:0] lfsr_state;
  int          cycle_count = 0;
  int          frame_period[2];
  int          period;
  string       cmp_name_q[$];
  logic [31:0] cmp_got_q[$];
  logic [31:0] cmp_exp_q[$];

  uart #(
    .CLOCK_FREQ_HZ(CLOCK_FREQ_HZ),
    .BAUD_RATE(BAUD_RATE),
    .FIFO_DEPTH(FIFO_DEPTH)
  ) uart_inst (
    .clock(clock), .reset(reset), .rd_en(rd_en), .wr_en(wr_en), .addr(addr),
    .wr_data(wr_data), .rxd(rxd), .rd_data(rd_data), .busy(busy), .irq(irq), .txd(txd)
  );

  initial begin
    clock = 1'b0;
    forever #2 clock = ~clock;
  end

  always @(posedge clock) begin
    cycle_count <= cycle_count + 1;
    if (cycle_count >= CYCLE_LIMIT) begin
      $display("Timeout: the run did not finish within %0d cycles, the DUT hangs", CYCLE_LIMIT);
      $display(">>> FAIL");
      $fatal(1, "Simulation stopped by the cycle limit");
    end
  end

  // Comparer drains the pending checks
  always @(posedge clock) begin
    while (cmp_got_q.size() > 0) begin
      check_value(cmp_name_q.pop_front(), cmp_got_q.pop_front(), cmp_exp_q.pop_front());
    end
  end

  task automatic check_value(input string name, input logic [31:0] got, input logic [31:0] want);
    if (got !== want) begin
      $display("FAILED at %0d ns: %s is %h, expected %h", $time, name, got, want);
      $display(">>> FAIL");
      $fatal(1, "Mismatch on %s", name);
    end
  endtask

  function automatic void queue_compare(input string name, input logic [31:0] got,
                                        input logic [31:0] want);
    cmp_name_q.push_back(name);
    cmp_got_q.push_back(got);
    cmp_exp_q.push_back(want);
  endfunction

  // Taps 32, 22, 2 and 1
  function automatic logic [31:0] lfsr_step(input logic [31:0] s);
    return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
  endfunction

  function automatic logic [7:0] random_byte();
    logic [7:0] b;
    b = '0;
    for (int i = 0; i < 8; i++) begin
      lfsr_state = lfsr_step(lfsr_state);
      b = {b[6:0], lfsr_state[0]};
    end
    return b;
  endfunction

  function automatic logic [1:0] expected_ip();
    logic rxwm;
    logic txwm;
    rxwm = (exp_rx.size() > int'(m_rx_wm)) && m_ie[1];
    txwm = (exp_tx.size() < int'(m_tx_wm)) && m_ie[0];
    return {rxwm, txwm};
  endfunction

  function automatic logic [31:0] expected_read(input logic [2:0] slot);
    logic [31:0] w;
    w = '0;
    case (slot)
      uart_regs_pkg::TXDATA: w[uart_regs_pkg::FULL_BIT] = (exp_tx.size() == FIFO_DEPTH);
      uart_regs_pkg::RXDATA: begin
        if (exp_rx.size() == 0) begin
          w[uart_regs_pkg::EMPTY_BIT] = 1'b1;
        end else begin
          w[uart_regs_pkg::FERR_BIT] = exp_rx[0][8];
          w[7:0]                     = exp_rx[0][7:0];
        end
      end
      uart_regs_pkg::TXCTRL: w = {13'd0, m_tx_wm, 14'd0, m_tx_two, m_tx_en};
      uart_regs_pkg::RXCTRL: w = {13'd0, m_rx_wm, 15'd0, m_rx_en};
      uart_regs_pkg::IE:     w[1:0] = m_ie;
      uart_regs_pkg::IP:     w[1:0] = expected_ip();
      uart_regs_pkg::DIV:    w[15:0] = m_div;
      default:               w = '0;
    endcase
    return w;
  endfunction

  task automatic wait_idle();
    while (busy) @(negedge clock);
  endtask

  task automatic bus_write(input logic [2:0] slot, input logic [31:0] data);
    @(negedge clock);
    wr_en   = 1'b1;
    addr    = {slot, 2'b00};
    wr_data = data;
    @(negedge clock);
    wr_en = 1'b0;
    wait_idle();
    case (slot)
      uart_regs_pkg::TXDATA: begin
        if (exp_tx.size() < FIFO_DEPTH) exp_tx.push_back(data[7:0]);
      end
      uart_regs_pkg::TXCTRL: begin
        m_tx_en  = data[0];
        m_tx_two = data[1];
        m_tx_wm  = data[18:16];
      end
      uart_regs_pkg::RXCTRL: begin
        m_rx_en = data[0];
        m_rx_wm = data[18:16];
      end
      uart_regs_pkg::IE:  m_ie = data[1:0];
      uart_regs_pkg::DIV: m_div = data[15:0];
      default: ;
    endcase
  endtask

  task automatic bus_read(input logic [2:0] slot, output logic [31:0] data);
    @(negedge clock);
    rd_en = 1'b1;
    addr  = {slot, 2'b00};
    @(negedge clock);
    rd_en = 1'b0;
    wait_idle();
    data = rd_data;
  endtask

  task automatic read_compare(input logic [2:0] slot, input string name);
    logic [31:0] want;
    logic [31:0] got;
    want = expected_read(slot);
    bus_read(slot, got);
    // A read of RXDATA consumes the head
    if (slot == uart_regs_pkg::RXDATA && exp_rx.size() > 0) begin
      void'(exp_rx.pop_front());
    end
    queue_compare(name, got, want);
  endtask

  task automatic check_irq();
    queue_compare("irq", 32'(irq), 32'(|expected_ip()));
  endtask

  // Start bit, data LSB first, one stop bit, then two idle bit times
  task automatic send_frame(input logic [7:0] data, input logic bad_stop);
    logic [9:0] bits;
    bits = {~bad_stop, data, 1'b0};
    for (int i = 0; i < 10; i++) begin
      @(negedge clock);
      rxd = bits[i];
      repeat (BIT_CYCLES - 1) @(negedge clock);
    end
    @(negedge clock);
    rxd = 1'b1;
    repeat (2 * BIT_CYCLES - 1) @(negedge clock);
    if (m_rx_en && exp_rx.size() < FIFO_DEPTH) exp_rx.push_back({bad_stop, data});
  endtask

  // Samples each bit in its middle and measures the gap between the first two starts
  task automatic capture_tx_frames(input int count, input logic two_stop, output int gap);
    logic [7:0] got;
    int         start_prev;
    int         start_now;
    gap        = 0;
    start_prev = 0;
    for (int n = 0; n < count; n++) begin
      while (txd !== 1'b0) @(negedge clock);
      start_now = cycle_count;
      if (n == 1) gap = start_now - start_prev;
      start_prev = start_now;
      repeat (BIT_CYCLES / 2) @(negedge clock);
      queue_compare("txd start bit", 32'(txd), 32'd0);
      for (int b = 0; b < 8; b++) begin
        repeat (BIT_CYCLES) @(negedge clock);
        got[b] = txd;
      end
      for (int s = 0; s < (two_stop ? 2 : 1); s++) begin
        repeat (BIT_CYCLES) @(negedge clock);
        queue_compare("txd stop bit", 32'(txd), 32'd1);
      end
      queue_compare("txd data byte", 32'(got), 32'(exp_tx.pop_front()));
    end
  endtask

  initial begin
    reset      = 1'b1;
    rd_en      = 1'b0;
    wr_en      = 1'b0;
    addr       = '0;
    wr_data    = '0;
    rxd        = 1'b1;
    lfsr_state = 32'ha4bb7a96;
    m_tx_en    = 1'b0;
    m_tx_two   = 1'b0;
    m_tx_wm    = '0;
    m_rx_en    = 1'b0;
    m_rx_wm    = '0;
    m_ie       = '0;
    m_div      = 16'(CLOCK_FREQ_HZ / BAUD_RATE - 1);
    repeat (5) @(posedge clock);
    @(negedge clock);
    reset = 1'b0;

    // Reset state
    queue_compare("busy", 32'(busy), 32'd0);
    queue_compare("irq", 32'(irq), 32'd0);
    queue_compare("txd", 32'(txd), 32'd1);
    for (int s = 0; s < 8; s++) begin
      read_compare(3'(s), $sformatf("slot %0d after reset", s));
    end

    // Only defined fields stick and DIV ends at 15 for 16 cycles per bit
    bus_write(uart_regs_pkg::TXCTRL, 32'hffff_ffff);
    bus_write(uart_regs_pkg::RXCTRL, 32'hffff_ffff);
    bus_write(uart_regs_pkg::IE, 32'hffff_ffff);
    bus_write(uart_regs_pkg::IP, 32'hffff_ffff);
    bus_write(3'd7, 32'hffff_ffff);
    bus_write(uart_regs_pkg::DIV, 32'ha5a5_000f);
    for (int s = 2; s < 8; s++) begin
      read_compare(3'(s), $sformatf("slot %0d after write", s));
    end
    check_irq();
    bus_write(uart_regs_pkg::TXCTRL, 32'h0);
    bus_write(uart_regs_pkg::RXCTRL, 32'h0);
    bus_write(uart_regs_pkg::IE, 32'h0);
    check_irq();

    // Transmit with one and then two stop bits
    for (int two = 0; two < 2; two++) begin
      for (int i = 0; i < 4; i++) begin
        bus_write(uart_regs_pkg::TXDATA, {24'd0, random_byte()});
      end
      fork
        bus_write(uart_regs_pkg::TXCTRL, 32'((two << 1) | 1));
        capture_tx_frames(4, 1'(two), period);
      join
      frame_period[two] = period;
      bus_write(uart_regs_pkg::TXCTRL, 32'h0);
    end
    queue_compare("extra stop bit time", 32'(frame_period[1] - frame_period[0]),
                  32'(BIT_CYCLES));

    // Fill the transmit FIFO past full while watching txwm
    bus_write(uart_regs_pkg::TXCTRL, 32'h0003_0000);
    bus_write(uart_regs_pkg::IE, 32'h1);
    for (int i = 0; i <= FIFO_DEPTH; i++) begin
      bus_write(uart_regs_pkg::TXDATA, {24'd0, random_byte()});
      read_compare(uart_regs_pkg::IP, "IP while filling tx");
      check_irq();
    end
    read_compare(uart_regs_pkg::TXDATA, "TXDATA full flag");
    fork
      bus_write(uart_regs_pkg::TXCTRL, 32'h0003_0001);
      capture_tx_frames(FIFO_DEPTH, 1'b0, period);
    join
    bus_write(uart_regs_pkg::TXCTRL, 32'h0);
    bus_write(uart_regs_pkg::IE, 32'h0);
    read_compare(uart_regs_pkg::TXDATA, "TXDATA after drain");

    // Receive with the rxwm interrupt enabled
    bus_write(uart_regs_pkg::RXCTRL, 32'h0002_0001);
    bus_write(uart_regs_pkg::IE, 32'h2);
    for (int i = 0; i < 4; i++) begin
      send_frame(random_byte(), 1'b0);
      read_compare(uart_regs_pkg::IP, "IP while receiving");
      check_irq();
    end
    for (int i = 0; i < 5; i++) begin
      read_compare(uart_regs_pkg::RXDATA, "RXDATA good frame");
    end
    send_frame(random_byte(), 1'b1);
    read_compare(uart_regs_pkg::RXDATA, "RXDATA framing error");
    read_compare(uart_regs_pkg::RXDATA, "RXDATA empty after error");

    // Receiver off
    bus_write(uart_regs_pkg::RXCTRL, 32'h0);
    send_frame(random_byte(), 1'b0);
    send_frame(random_byte(), 1'b0);
    read_compare(uart_regs_pkg::RXDATA, "RXDATA with receive off");

    // Overflow keeps the first FIFO_DEPTH frames
    bus_write(uart_regs_pkg::RXCTRL, 32'h1);
    for (int i = 0; i <= FIFO_DEPTH; i++) begin
      send_frame(random_byte(), 1'b0);
    end
    read_compare(uart_regs_pkg::IP, "IP after overflow");
    check_irq();
    for (int i = 0; i <= FIFO_DEPTH; i++) begin
      read_compare(uart_regs_pkg::RXDATA, "RXDATA after overflow");
    end

    @(posedge clock);
    @(negedge clock);
    if (cmp_got_q.size() == 0) begin
      $display(">>> PASS");
      $finish;
    end else begin
      $display("Some comparisons were still pending at the end of the run");
      $display(">>> FAIL");
      $fatal(1, "Comparisons left pending at the end of the run");
    end
  end

endmodule

`default_nettype wire

//--- src.f
design/uart_regs_pkg.sv
design/uart_line_pkg.sv
design/uart_fifo.sv
design/uart_baud_gen.sv
design/uart_tx.sv
design/uart_rx.sv
design/uart.sv
testbench/uart_tb.sv

//--- Makefile
TOP := uart_tb
LOG := sim.log

.PHONY: help test clean

help:
	@echo "make test   build with Verilator, run the testbench and check $(LOG)"
	@echo "make clean  remove the build directory and the log"
	@echo "make help   show this list"

test:
	verilator --binary --timing --assert --top-module $(TOP) -f src.f -o $(TOP)
	./obj_dir/$(TOP) | tee $(LOG)
	@grep -qx '>>> PASS' $(LOG) || (echo "Test failed, see $(LOG)"; exit 1)
	@echo "Test passed"

clean:
	rm -rf obj_dir $(LOG)
